/* sim.f */
logic/issue_pkg.sv
logic/instr_queue.sv
logic/queue_tracker.sv
logic/pair_check.sv
logic/issue_control.sv
logic/issue_stage.sv
bench/issue_stage_props.sv
bench/issue_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= issue_stage_tb
OBJ_DIR ?= obj_dir
FILELIST ?= sim.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@grep -q "^TESTS PASSED$$" $(LOG) && echo "Simulation passed, see $(LOG)" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/issue_stage_tb.sv */
`timescale 1ns/1ns

module issue_stage_tb import issue_pkg::*; ();

  typedef enum int {
    mode_stream,
    mode_depend,
    mode_units,
    mode_serial,
    mode_pressure,
    mode_flush
  } mode_t;

  logic clock = 1'b0;
  logic reset;
  logic clear;
  logic done;
  logic exec_stall;
  issue_t fetch;
  issue_t issue;
  logic stall;

  instr_t model_q[$]; // Accepted, not yet issued
  logic model_wait;
  logic model_stall;
  logic fetch_taken; // Decoder may present a new pair
  logic serial_issued;
  logic flush_pending;
  logic flush_pc_known;
  logic [31:0] flush_pc;
  logic [31:0] pc_next;

  int seed_value;
  int done_wait;
  int cycle_count = 0;
  int cycle_limit;
  int error_count;
  int check_count;
  int tests_run;
  int accepted;
  int issued;
  int flushed;
  int dual_count;
  int stall_cycles;

  issue_stage u_dut (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .done(done),
    .exec_stall(exec_stall),
    .fetch(fetch),
    .issue(issue),
    .stall(stall)
  );

  bind issue_stage issue_stage_props u_props (
    .clock(clock),
    .reset(reset),
    .exec_stall(exec_stall),
    .issue(issue),
    .stall(stall)
  );

  always #20 clock = ~clock;

  // ****************************************
  // Reference model
  // ****************************************

  function automatic logic can_pair(input instr_t first, input instr_t second);
    logic dep;
    logic shared;
    dep = first.wren && (first.waddr != 5'd0) &&
          ((second.rden1 && second.raddr1 == first.waddr) ||
           (second.rden2 && second.raddr2 == first.waddr));
    shared = (first.unit == second.unit) &&
             (first.unit == mul || first.unit == div || first.unit == csr);
    return !dep && !shared;
  endfunction

  function automatic issue_t model_issue(input logic waiting, input logic hold);
    issue_t exp;
    exp = '0;
    if (!waiting && !hold && model_q.size() > 0) begin
      exp.slot0 = model_q[0];
      if (model_q.size() > 1 && !model_q[0].serial && !model_q[1].serial &&
          can_pair(model_q[0], model_q[1])) begin
        exp.slot1 = model_q[1];
      end
    end
    return exp;
  endfunction

  task automatic accept_fetch();
    if (fetch.slot0.valid) begin
      model_q.push_back(fetch.slot0);
      accepted++;
      if (flush_pending && !flush_pc_known) begin
        flush_pc = fetch.slot0.pc; // First instruction after the clear
        flush_pc_known = 1'b1;
      end
    end
    if (fetch.slot1.valid) begin
      model_q.push_back(fetch.slot1);
      accepted++;
    end
  endtask

  task automatic compare_cycle();
    issue_t exp;
    int width;
    check_count++;
    if (stall !== model_stall) begin
      $display("** Error at %0t: stall expected %b, got %b", $time, model_stall, stall);
      error_count++;
    end
    if (stall) stall_cycles++;
    if (clear) begin
      flushed += model_q.size();
      model_q.delete();
      model_wait = 1'b0;
      flush_pending = 1'b1;
      flush_pc_known = 1'b0;
      exp = '0;
    end else begin
      if (!model_stall) accept_fetch();
      exp = model_issue(model_wait, exec_stall);
    end
    if (issue !== exp) begin
      $display("** Error at %0t: issue expected %h, got %h", $time, exp, issue);
      error_count++;
    end
    if (flush_pending && issue.slot0.valid) begin
      if (!flush_pc_known) begin
        $display("** Error at %0t: pc %h issued before any fetch after clear",
                 $time, issue.slot0.pc);
        error_count++;
      end else if (issue.slot0.pc !== flush_pc) begin
        $display("** Error at %0t: first issue after clear pc %h, expected %h",
                 $time, issue.slot0.pc, flush_pc);
        error_count++;
      end
      flush_pending = 1'b0;
    end
    width = int'(exp.slot0.valid) + int'(exp.slot1.valid);
    repeat (width) void'(model_q.pop_front());
    issued += int'(issue.slot0.valid) + int'(issue.slot1.valid);
    if (issue.slot1.valid) dual_count++;
    if (model_wait && done) begin
      model_wait = 1'b0;
    end else if (exp.slot0.valid && exp.slot0.serial) begin
      model_wait = 1'b1;
    end
    model_stall = (model_q.size() > stall_level);
    fetch_taken = clear || !stall;
    serial_issued = issue.slot0.valid && issue.slot0.serial;
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clock) begin
    if (!reset) begin
      model_q.delete();
      model_wait = 1'b0;
      model_stall = 1'b0;
      fetch_taken = 1'b1;
      serial_issued = 1'b0;
    end else begin
      compare_cycle();
    end
  end

  // ****************************************
  // Execute side and timeout
  // ****************************************

  always @(posedge clock) begin
    done <= 1'b0;
    if (!reset || clear) begin
      done_wait = 0;
    end else begin
      if (serial_issued) done_wait = $urandom_range(5, 1);
      if (done_wait == 1) done <= 1'b1;
      if (done_wait > 0) done_wait = done_wait - 1;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the run did not finish", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ****************************************
  // Stimulus
  // ****************************************

  function automatic instr_t rand_instr(input mode_t mode, input logic [31:0] pc);
    instr_t ins;
    int pick;
    ins = instr_none;
    ins.valid = 1'b1;
    ins.pc = pc;
    ins.wren = ($urandom_range(3, 0) != 0);
    ins.rden1 = 1'($urandom_range(1, 0));
    ins.rden2 = 1'($urandom_range(1, 0));
    ins.waddr = 5'($urandom);
    ins.raddr1 = 5'($urandom);
    ins.raddr2 = 5'($urandom);
    if (mode == mode_depend) begin
      ins.waddr = 5'($urandom_range(2, 0)); // Few registers, many hazards
      ins.raddr1 = 5'($urandom_range(2, 0));
      ins.raddr2 = 5'($urandom_range(2, 0));
    end
    pick = $urandom_range(3, 0);
    if (mode == mode_stream) begin
      ins.unit = (pick < 2) ? alu : lsu;
    end else if (mode == mode_units) begin
      case (pick)
        0: ins.unit = mul;
        1: ins.unit = div;
        2: ins.unit = csr;
        default: ins.unit = alu;
      endcase
    end else begin
      ins.unit = (pick == 0) ? lsu : (pick == 1) ? bcu : (pick == 2) ? mul : alu;
    end
    ins.serial = (mode == mode_serial || mode == mode_flush) && ($urandom_range(5, 0) == 0);
    return ins;
  endfunction

  task automatic drive_cycle(input mode_t mode);
    issue_t next;
    next = '0;
    @(posedge clock);
    if (fetch_taken) begin
      if ($urandom_range(3, 0) != 0) begin
        next.slot0 = rand_instr(mode, pc_next);
        pc_next = pc_next + 32'd4;
        if ($urandom_range(1, 0) == 1) begin
          next.slot1 = rand_instr(mode, pc_next);
          pc_next = pc_next + 32'd4;
        end
      end
      fetch <= next;
    end
    exec_stall <= (mode == mode_pressure) && ($urandom_range(1, 0) == 1);
    clear <= (mode == mode_flush) && ($urandom_range(19, 0) == 0);
  endtask

  // Keep a stalled pair until it is taken, then let the queue empty
  task automatic drain(input string name);
    int waited;
    waited = 0;
    do begin
      @(posedge clock);
      if (fetch_taken) fetch <= '0;
      exec_stall <= 1'b0;
      clear <= 1'b0;
      waited++;
    end while ((fetch.slot0.valid || model_q.size() != 0 || model_wait) && waited < 150);
    if (waited >= 150) begin
      $display("Queue did not drain within 150 cycles in test %s", name);
      error_count++;
    end
  endtask

  task automatic run_test(input string name, input mode_t mode, input int cycles);
    int start_errors;
    start_errors = error_count;
    accepted = 0;
    issued = 0;
    flushed = 0;
    dual_count = 0;
    stall_cycles = 0;
    repeat (cycles) drive_cycle(mode);
    drain(name);
    if (accepted != issued + flushed) begin
      $display("** Error at %0t: %0d accepted but %0d issued and %0d flushed",
               $time, accepted, issued, flushed);
      error_count++;
    end
    tests_run++;
    $display("%-10s accepted %0d issued %0d pairs %0d stalled %0d errors %0d",
             name, accepted, issued, dual_count, stall_cycles, error_count - start_errors);
  endtask

  initial begin
    seed_value = $urandom(47);
    cycle_limit = 6000; // Six tests of 800 cycles, drains and reset
    reset = 1'b0;
    clear = 1'b0;
    done = 1'b0;
    exec_stall = 1'b0;
    fetch = '0;
    pc_next = 32'h0000_1000;
    done_wait = 0;
    error_count = 0;
    check_count = 0;
    tests_run = 0;
    flush_pending = 1'b0;
    flush_pc_known = 1'b0;
    flush_pc = '0;
    repeat (4) @(posedge clock);
    reset <= 1'b1;
    run_test("stream", mode_stream, 800);
    run_test("depend", mode_depend, 800);
    run_test("units", mode_units, 800);
    run_test("serial", mode_serial, 800);
    run_test("pressure", mode_pressure, 800);
    run_test("flush", mode_flush, 800);
    $display("Tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* bench/issue_stage_props.sv */
`timescale 1ns/1ns

module issue_stage_props import issue_pkg::*; (
  input logic clock,
  input logic reset,
  input logic exec_stall,
  input issue_t issue,
  input logic stall
);

  // ****************************************
  // Issue slot rules
  // ****************************************

  slot_order: assert property (@(posedge clock) disable iff (!reset)
    issue.slot1.valid |-> issue.slot0.valid)
    else $error("slot1 issued without slot0");

  serial_alone: assert property (@(posedge clock) disable iff (!reset)
    issue.slot1.valid |-> !issue.slot0.serial && !issue.slot1.serial)
    else $error("serializing instruction issued with a partner");

  // Execute back-pressure blocks both slots
  hold_on_stall: assert property (@(posedge clock) disable iff (!reset)
    exec_stall |-> !issue.slot0.valid && !issue.slot1.valid)
    else $error("instruction issued under exec_stall");

  // ****************************************
  // Reset
  // ****************************************

  stall_after_reset: assert property (@(posedge clock)
    $rose(reset) |-> !stall)
    else $error("decoder stall high right after reset");

endmodule

/* logic/issue_stage.sv */
`timescale 1ns/1ns

module issue_stage import issue_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  logic done,
  input  logic exec_stall,
  input  issue_t fetch,
  output issue_t issue,
  output logic stall
);

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0] count;
  logic accept;
  logic dual_ok;
  logic [1:0] issue_count;
  instr_t head0;
  instr_t head1;

  queue_tracker u_tracker (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .fetch(fetch),
    .issue_count(issue_count),
    .wr_ptr(wr_ptr),
    .rd_ptr(rd_ptr),
    .count(count),
    .accept(accept),
    .stall(stall)
  );

  instr_queue u_queue (
    .clock(clock),
    .reset(reset),
    .wr_ptr(wr_ptr),
    .rd_ptr(rd_ptr),
    .fetch(fetch),
    .accept(accept),
    .head0(head0),
    .head1(head1)
  );

  pair_check u_pair (
    .head0(head0),
    .head1(head1),
    .dual_ok(dual_ok)
  );

  issue_control u_control (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .done(done),
    .exec_stall(exec_stall),
    .head0(head0),
    .head1(head1),
    .count(count),
    .dual_ok(dual_ok),
    .issue_count(issue_count),
    .issue(issue)
  );

endmodule

/* logic/issue_control.sv */
`timescale 1ns/1ns

module issue_control import issue_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  logic done,
  input  logic exec_stall,
  input  instr_t head0,
  input  instr_t head1,
  input  logic [ptr_width:0] count,
  input  logic dual_ok,
  output logic [1:0] issue_count,
  output issue_t issue
);

  typedef enum logic {
    run,
    serial_wait
  } state_t;

  state_t state;
  state_t state_next;
  logic [1:0] wanted; // Issue width before the occupancy limit

  // ****************************************
  // Issue width
  // ****************************************

  always_comb begin
    wanted = 2'd0;
    if (state == run) begin
      if (head0.serial || head1.serial) begin
        wanted = 2'd1;
      end else if (dual_ok) begin
        wanted = 2'd2;
      end else begin
        wanted = 2'd1;
      end
      if (exec_stall) begin
        wanted = 2'd0; // Execute holds the pipe
      end
    end
    issue_count = wanted;
    if (count < (ptr_width+1)'(wanted)) begin
      issue_count = count[1:0];
    end
  end

  always_comb begin
    issue.slot0 = (issue_count != 2'd0) ? head0 : instr_none;
    issue.slot1 = (issue_count == 2'd2) ? head1 : instr_none;
  end

  // ****************************************
  // State machine
  // ****************************************

  always_comb begin
    state_next = state;
    case (state)
      run: if (issue_count != 2'd0 && head0.serial) state_next = serial_wait;
      serial_wait: if (done) state_next = run; // Resume the cycle after done
      default: state_next = run;
    endcase
    if (clear) begin
      state_next = run;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= run;
    end else begin
      state <= state_next;
    end
  end

endmodule

/* logic/pair_check.sv */
`timescale 1ns/1ns

module pair_check import issue_pkg::*; (
  input  instr_t head0,
  input  instr_t head1,
  output logic dual_ok
);

  logic writes_reg; // head0 produces a real register result
  logic src1_hit;
  logic src2_hit;
  logic raw_hazard;
  logic same_unit;
  logic unit_conflict;

  // ****************************************
  // Register dependence
  // ****************************************

  // x0 is never a true dependence
  assign writes_reg = head0.wren && (head0.waddr != 5'd0);

  assign src1_hit = head1.rden1 && (head1.raddr1 == head0.waddr);
  assign src2_hit = head1.rden2 && (head1.raddr2 == head0.waddr);

  assign raw_hazard = writes_reg && (src1_hit || src2_hit);

  // ****************************************
  // Structural conflict
  // ****************************************

  assign same_unit = (head0.unit == head1.unit);

  // ALU, LSU and BCU are duplicated, the rest are not
  assign unit_conflict = same_unit && single_copy(head0.unit);

  assign dual_ok = !raw_hazard && !unit_conflict;

endmodule

/* logic/queue_tracker.sv */
`timescale 1ns/1ns

module queue_tracker import issue_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  issue_t fetch,
  input  logic [1:0] issue_count,
  output logic [ptr_width-1:0] wr_ptr,
  output logic [ptr_width-1:0] rd_ptr,
  output logic [ptr_width:0] count,
  output logic accept,
  output logic stall
);

  logic [ptr_width:0] count_q; // Occupancy at the start of the cycle
  logic [ptr_width:0] count_next;
  logic [1:0] fetched;

  assign accept = ~stall;

  always_comb begin
    fetched = 2'd0;
    if (accept && !clear) begin
      fetched = {1'b0, fetch.slot0.valid} + {1'b0, fetch.slot1.valid};
    end
  end

  // Occupancy seen by the issue logic includes this cycle's writes
  assign count = clear ? '0 : count_q + (ptr_width+1)'(fetched);
  assign count_next = count - (ptr_width+1)'(issue_count);

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count_q <= '0;
      stall <= 1'b0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count_q <= '0;
      stall <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr + ptr_width'(fetched);
      rd_ptr <= rd_ptr + ptr_width'(issue_count);
      count_q <= count_next;
      stall <= (count_next > stall_level); // Leaves room for one more fetch pair
    end
  end

endmodule

/* logic/instr_queue.sv */
`timescale 1ns/1ns

module instr_queue import issue_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic [ptr_width-1:0] wr_ptr,
  input  logic [ptr_width-1:0] rd_ptr,
  input  issue_t fetch,
  input  logic accept,
  output instr_t head0,
  output instr_t head1
);

  instr_t mem [queue_depth];

  logic [ptr_width-1:0] wr_next;
  logic [ptr_width-1:0] rd_next;
  logic wr0;
  logic wr1;

  assign wr_next = wr_ptr + ptr_width'(1);
  assign rd_next = rd_ptr + ptr_width'(1);
  assign wr0 = accept & fetch.slot0.valid;
  assign wr1 = accept & fetch.slot1.valid;

  always_ff @(posedge clock) begin
    if (!reset) begin
      mem <= '{default: instr_none};
    end else begin
      if (wr0) begin
        mem[wr_ptr] <= fetch.slot0;
      end
      if (wr1) begin
        mem[wr_next] <= fetch.slot1; // Second slot lands right after the first
      end
    end
  end

  // Bypass lets a new instruction issue in the cycle it arrives
  always_comb begin
    head0 = mem[rd_ptr];
    if (wr0 && rd_ptr == wr_ptr) begin
      head0 = fetch.slot0;
    end else if (wr1 && rd_ptr == wr_next) begin
      head0 = fetch.slot1;
    end

    head1 = mem[rd_next];
    if (wr0 && rd_next == wr_ptr) begin
      head1 = fetch.slot0;
    end else if (wr1 && rd_next == wr_next) begin
      head1 = fetch.slot1;
    end
  end

endmodule

/* logic/issue_pkg.sv */
package issue_pkg;

  // ****************************************
  // Queue sizing
  // ****************************************

  localparam int queue_depth = 8; // Buffer entries
  localparam int ptr_width = 3; // Index into the buffer
  localparam int stall_level = 4; // Decoder stalls above this occupancy

  // ****************************************
  // Decoded instruction
  // ****************************************

  // Execution unit that an instruction needs
  typedef enum logic [2:0] {
    alu = 3'd0,
    lsu = 3'd1,
    bcu = 3'd2,
    mul = 3'd3,
    div = 3'd4,
    csr = 3'd5
  } unit_t;

  typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic [4:0] waddr; // Destination register
    logic [4:0] raddr1; // First source register
    logic [4:0] raddr2; // Second source register
    logic wren;
    logic rden1;
    logic rden2;
    unit_t unit;
    logic serial; // Fence, mret or wfi
  } instr_t;

  localparam instr_t instr_none = '0;

  // ****************************************
  // Issue bundle
  // ****************************************

  // Lone issue always goes out in slot0
  typedef struct packed {
    instr_t slot0;
    instr_t slot1;
  } issue_t;

  // Units with a single copy in the execute stage
  function automatic logic single_copy(input unit_t unit);
    logic result;
    case (unit)
      mul, div, csr: result = 1'b1;
      default: result = 1'b0;
    endcase
    return result;
  endfunction

endpackage
